/* source/spatz_pkg.sv */
// Shared widths, RVV field encodings and request types for the vector unit.
// Every RTL file imports this package inside its module body.
`default_nettype none

package spatz_pkg;

	//////////////////////////////
	// Widths and limits
	//////////////////////////////

	localparam int unsigned ELEN = 32;
	localparam int unsigned VLEN = 128;
	localparam int unsigned MAXVL = VLEN / ELEN;
	localparam int unsigned NR_VREGS = 32;
	// Element index bits inside one register
	localparam int unsigned VIDX_W = $clog2(MAXVL);
	// Largest legal vsew encoding for this ELEN
	localparam int unsigned ELEN_EW_IDX = $clog2(ELEN / 8);

	typedef logic [ELEN-1:0] elen_t;
	typedef logic [$clog2(MAXVL):0] vlen_t;
	typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;

	//////////////////////////////
	// RVV fields
	//////////////////////////////

	typedef enum logic [2:0] {
		EW_8  = 3'b000,
		EW_16 = 3'b001,
		EW_32 = 3'b010,
		EW_64 = 3'b011
	} vew_e;

	typedef enum logic [2:0] {
		LMUL_1   = 3'b000,
		LMUL_2   = 3'b001,
		LMUL_4   = 3'b010,
		LMUL_8   = 3'b011,
		LMUL_RES = 3'b100,
		LMUL_F8  = 3'b101,
		LMUL_F4  = 3'b110,
		LMUL_F2  = 3'b111
	} vlmul_e;

	typedef struct packed {
		logic   vill;
		logic   vma;
		logic   vta;
		vew_e   vsew;
		vlmul_e vlmul;
	} vtype_t;

	// Value after reset and after an illegal configuration
	localparam vtype_t VTYPE_VILL = '{vill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: EW_8, vlmul: LMUL_1};

	typedef enum logic [3:0] {
		VCFG, VADD, VSUB, VAND, VOR, VXOR, VMV_VX, VREDSUM, VMV_XS, VNONE
	} op_e;

	typedef struct packed {
		logic keep_vl;
	} op_cfg_t;

	// Decoded instruction with its scalar operands
	typedef struct packed {
		logic    valid;
		logic    illegal;
		op_e     op;
		op_cfg_t op_cfg;
		vtype_t  vtype;
		vreg_t   vd;
		vreg_t   vs1;
		vreg_t   vs2;
		elen_t   rs1;
		elen_t   rs2;
		logic    use_scalar;
		logic    vlmax_req;
	} spatz_req_t;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	localparam logic [6:0] OPV = 7'b1010111;

	localparam logic [2:0] OPIVV = 3'b000;
	localparam logic [2:0] OPMVV = 3'b010;
	localparam logic [2:0] OPIVX = 3'b100;
	localparam logic [2:0] OPMVX = 3'b110;
	localparam logic [2:0] OPCFG = 3'b111;

	localparam logic [5:0] F6_VADD     = 6'b000000;
	localparam logic [5:0] F6_VSUB     = 6'b000010;
	localparam logic [5:0] F6_VAND     = 6'b001001;
	localparam logic [5:0] F6_VOR      = 6'b001010;
	localparam logic [5:0] F6_VXOR     = 6'b001011;
	localparam logic [5:0] F6_VMV      = 6'b010111;
	localparam logic [5:0] F6_VREDSUM  = 6'b000000;
	localparam logic [5:0] F6_VWXUNARY = 6'b010000;

endpackage

`default_nettype wire

/* source/spatz_decoder.sv */
// Instruction decoder. Turns a strobed RVV instruction and its scalar
// operands into a registered request, valid for one cycle after the strobe.
`timescale 1ns/1ps
`default_nettype none

module spatz_decoder (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  logic [31:0]            instr_i,
	input  logic                   instr_valid_i,
	input  spatz_pkg::elen_t       rs1_i,
	input  spatz_pkg::elen_t       rs2_i,
	output spatz_pkg::spatz_req_t  req_o
);
	import spatz_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [5:0] funct6;
	logic       vm;
	vreg_t      rd;
	vreg_t      rs1;
	vreg_t      rs2;
	spatz_req_t req_d;
	spatz_req_t req_q;
	logic       valid_q;

	assign opcode = instr_i[6:0];
	assign rd     = instr_i[11:7];
	assign funct3 = instr_i[14:12];
	assign rs1    = instr_i[19:15];
	assign rs2    = instr_i[24:20];
	assign vm     = instr_i[25];
	assign funct6 = instr_i[31:26];

	// vtype layout: vma, vta, vsew, vlmul in the low byte
	function automatic vtype_t make_vtype(input logic [7:0] f, input logic resv);
		vtype_t t;
		t.vill  = resv;
		t.vma   = f[7];
		t.vta   = f[6];
		t.vsew  = vew_e'(f[5:3]);
		t.vlmul = vlmul_e'(f[2:0]);
		return t;
	endfunction

	always_comb begin
		req_d     = '0;
		req_d.op  = VNONE;
		req_d.vd  = rd;
		req_d.vs1 = rs1;
		req_d.vs2 = rs2;
		req_d.rs1 = rs1_i;
		req_d.rs2 = rs2_i;
		if (opcode == OPV) begin
			unique case (funct3)
				OPCFG: begin
					req_d.op_cfg.keep_vl = (rs1 == '0) && (rd == '0);
					req_d.vlmax_req      = (rs1 == '0) && (rd != '0);
					if (!instr_i[31]) begin
						// vsetvli, zimm[10:8] must be zero
						req_d.op    = VCFG;
						req_d.vtype = make_vtype(instr_i[27:20], |instr_i[30:28]);
					end else if (instr_i[30:25] == '0) begin
						// vsetvl
						req_d.op    = VCFG;
						req_d.vtype = make_vtype(rs2_i[7:0], |rs2_i[31:8]);
					end
				end
				OPIVV, OPIVX: begin
					req_d.use_scalar = (funct3 == OPIVX);
					unique case (funct6)
						F6_VADD: req_d.op = VADD;
						F6_VSUB: req_d.op = VSUB;
						F6_VAND: req_d.op = VAND;
						F6_VOR:  req_d.op = VOR;
						F6_VXOR: req_d.op = VXOR;
						F6_VMV:  req_d.op = (rs2 == '0) ? VMV_VX : VNONE;
						default: req_d.op = VNONE;
					endcase
					// Only vadd and vmv exist in the scalar form here
					if (funct3 == OPIVX && !(req_d.op inside {VADD, VMV_VX}))
						req_d.op = VNONE;
					if (funct3 == OPIVV && req_d.op == VMV_VX)
						req_d.op = VNONE;
				end
				OPMVV: begin
					if (funct6 == F6_VREDSUM)
						req_d.op = VREDSUM;
					else if (funct6 == F6_VWXUNARY && rs1 == '0)
						req_d.op = VMV_XS;
				end
				// vmv.s.x and the other scalar moves are not implemented
				OPMVX: req_d.op = VNONE;
				default: req_d.op = VNONE;
			endcase
		end
		// Masked forms are not supported, vsetvl has bit 25 cleared
		req_d.illegal = (req_d.op == VNONE) || (req_d.op != VCFG && !vm);
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= instr_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (instr_valid_i) begin
			req_q <= req_d;
		end
	end

	always_comb begin
		req_o       = req_q;
		req_o.valid = valid_q;
	end

endmodule

`default_nettype wire

/* source/spatz_vcsr.sv */
// Vector CSRs vstart, vl and vtype. A configuration write checks the new
// vtype and applies the stripmining rule for vl.
`timescale 1ns/1ps
`default_nettype none

module spatz_vcsr (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  cfg_we_i,
	input  spatz_pkg::spatz_req_t req_i,
	output spatz_pkg::vlen_t      vl_o,
	output spatz_pkg::vlen_t      vstart_o,
	output spatz_pkg::vtype_t     vtype_o
);
	import spatz_pkg::*;

	vlen_t      vl_q;
	vtype_t     vtype_q;
	logic [2:0] lmul_bits;
	logic [2:0] sew_bits;
	logic       frac_ok;
	logic       vtype_bad;
	vlen_t      avl_clip;

	assign lmul_bits = req_i.vtype.vlmul;
	assign sew_bits  = req_i.vtype.vsew;

	// Fractional LMUL needs SEW <= ELEN * LMUL
	assign frac_ok = !lmul_bits[2]
		|| ((sew_bits + (3'd4 - {1'b0, lmul_bits[1:0]})) <= ELEN_EW_IDX);

	assign vtype_bad = req_i.vtype.vill || (req_i.vtype.vsew > EW_32)
		|| (req_i.vtype.vlmul == LMUL_RES) || !frac_ok;

	assign avl_clip = (req_i.rs1 > MAXVL) ? vlen_t'(MAXVL) : vlen_t'(req_i.rs1);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			vtype_q  <= VTYPE_VILL;
			vl_q     <= '0;
		end else if (cfg_we_i) begin
			if (vtype_bad) begin
				vtype_q <= VTYPE_VILL;
				vl_q    <= '0;
			end else begin
				vtype_q <= req_i.vtype;
				if (req_i.vlmax_req)
					vl_q <= vlen_t'(MAXVL);
				else if (!req_i.op_cfg.keep_vl)
					vl_q <= avl_clip;
			end
		end
	end

	assign vl_o     = vl_q;
	// No resumption, so vstart always reads as zero
	assign vstart_o = '0;
	assign vtype_o  = vtype_q;

endmodule

`default_nettype wire

/* source/spatz_controller.sv */
// Sequencer for accepted requests. Decides legality, drives the CSR write,
// the element counter, the register file ports and the functional unit.
`timescale 1ns/1ps
`default_nettype none

module spatz_controller (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  spatz_pkg::spatz_req_t req_i,
	input  spatz_pkg::vlen_t      vl_i,
	input  spatz_pkg::vtype_t     vtype_i,
	input  logic                  last_i,
	input  spatz_pkg::vlen_t      elem_idx_i,
	input  spatz_pkg::elen_t      vs2_data_i,
	input  spatz_pkg::elen_t      acc_i,
	output logic                  cfg_we_o,
	output logic                  cnt_start_o,
	output logic                  cnt_step_o,
	output logic                  vrf_we_o,
	output spatz_pkg::vreg_t      vrf_waddr_o,
	output spatz_pkg::vlen_t      vrf_welem_o,
	output spatz_pkg::vreg_t      vrf_raddr1_o,
	output spatz_pkg::vreg_t      vrf_raddr2_o,
	output spatz_pkg::vlen_t      vrf_relem_o,
	output logic                  acc_init_o,
	output logic                  acc_en_o,
	output spatz_pkg::op_e        op_o,
	output spatz_pkg::elen_t      rs1_o,
	output logic                  use_scalar_o,
	output logic                  busy_o,
	output logic                  instr_illegal_o,
	output spatz_pkg::elen_t      rd_o,
	output logic                  rd_valid_o
);
	import spatz_pkg::*;

	typedef enum logic [1:0] {IDLE, EXEC, REDWB, RESP} state_e;

	state_e     state_q, state_d;
	spatz_req_t req_q;
	elen_t      rd_q;
	logic       busy_q;
	logic       vec_bad;
	logic       accept;
	logic       exec_start;
	logic       in_exec;
	logic       is_red;

	//////////////////////////////
	// Acceptance
	//////////////////////////////

	// Vector ops need a legal vtype with SEW 32 and LMUL 1
	assign vec_bad = (req_i.op != VCFG)
		&& (vtype_i.vill || vtype_i.vsew != EW_32 || vtype_i.vlmul != LMUL_1);

	// busy_q is busy_o seen during the strobe cycle
	assign instr_illegal_o = req_i.valid && (req_i.illegal || busy_q || vec_bad);
	assign accept          = req_i.valid && !instr_illegal_o;
	assign cfg_we_o        = accept && req_i.op == VCFG;
	assign exec_start      = accept && !(req_i.op inside {VCFG, VMV_XS});
	assign cnt_start_o     = exec_start;

	assign in_exec = (state_q == EXEC);
	assign is_red  = (req_q.op == VREDSUM);
	assign busy_o  = exec_start || in_exec || state_q == REDWB;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			EXEC:  if (last_i) state_d = is_red ? REDWB : IDLE;
			REDWB: state_d = IDLE;
			default: begin
				// RESP takes new work just like IDLE
				state_d = IDLE;
				if (cfg_we_o || (accept && req_i.op == VMV_XS))
					state_d = RESP;
				else if (exec_start && vl_i != '0)
					state_d = EXEC;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= IDLE;
			busy_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			busy_q  <= busy_o;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept)
			req_q <= req_i;
		// rd also keeps the last reduction sum
		if (accept && req_i.op == VMV_XS)
			rd_q <= vs2_data_i;
		else if (state_q == REDWB)
			rd_q <= acc_i;
	end

	//////////////////////////////
	// Datapath steering
	//////////////////////////////

	assign cnt_step_o   = in_exec;
	assign vrf_we_o     = (in_exec && !is_red) || state_q == REDWB;
	assign vrf_waddr_o  = req_q.vd;
	assign vrf_welem_o  = (state_q == REDWB) ? '0 : elem_idx_i;
	assign vrf_raddr1_o = req_q.vs1;
	// Outside EXEC port 2 serves vmv.x.s from element 0
	assign vrf_raddr2_o = in_exec ? req_q.vs2 : req_i.vs2;
	assign vrf_relem_o  = in_exec ? elem_idx_i : '0;

	assign acc_init_o   = in_exec && is_red && elem_idx_i == '0;
	assign acc_en_o     = in_exec && is_red;
	assign op_o         = req_q.op;
	assign rs1_o        = req_q.rs1;
	assign use_scalar_o = req_q.use_scalar;

	assign rd_valid_o = (state_q == RESP);
	assign rd_o       = (req_q.op == VCFG) ? elen_t'(vl_i) : rd_q;

endmodule

`default_nettype wire

/* source/spatz_elem_counter.sv */
// Element index counter for one vector operation, from 0 to vl-1
`timescale 1ns/1ps
`default_nettype none

module spatz_elem_counter (
	input  logic             clk_i,
	input  logic             reset_i,
	input  logic             start_i,
	input  logic             step_i,
	input  spatz_pkg::vlen_t vl_i,
	output spatz_pkg::vlen_t idx_o,
	output logic             last_o
);
	import spatz_pkg::*;

	vlen_t idx_q;

	always_ff @(posedge clk_i) begin
		if (reset_i || start_i) begin
			idx_q <= '0;
		end else if (step_i) begin
			idx_q <= idx_q + 1'b1;
		end
	end

	assign idx_o = idx_q;
	// vl of 0 wraps to all ones and never matches
	assign last_o = (idx_q == vl_i - 1'b1);

endmodule

`default_nettype wire

/* source/spatz_vrf.sv */
// Vector register file. One synchronous write port and two combinational
// read ports that share the element index.
`timescale 1ns/1ps
`default_nettype none

module spatz_vrf (
	input  logic             clk_i,
	input  logic             reset_i,
	input  logic             we_i,
	input  spatz_pkg::vreg_t waddr_i,
	input  spatz_pkg::vlen_t welem_i,
	input  spatz_pkg::elen_t wdata_i,
	input  spatz_pkg::vreg_t raddr1_i,
	input  spatz_pkg::vreg_t raddr2_i,
	input  spatz_pkg::vlen_t relem_i,
	output spatz_pkg::elen_t rdata1_o,
	output spatz_pkg::elen_t rdata2_o
);
	import spatz_pkg::*;

	// One packed row of MAXVL elements per register
	elen_t [MAXVL-1:0] mem_q [NR_VREGS];

	logic [VIDX_W-1:0] widx;
	logic [VIDX_W-1:0] ridx;

	assign widx = welem_i[VIDX_W-1:0];
	assign ridx = relem_i[VIDX_W-1:0];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int r = 0; r < NR_VREGS; r++) begin
				mem_q[r] <= '0;
			end
		end else if (we_i) begin
			mem_q[waddr_i][widx] <= wdata_i;
		end
	end

	assign rdata1_o = mem_q[raddr1_i][ridx];
	assign rdata2_o = mem_q[raddr2_i][ridx];

endmodule

`default_nettype wire

/* source/spatz_vfu.sv */
// Integer functional unit. Element-wise ALU plus the reduction accumulator,
// whose value is the result while a vredsum writes back.
`timescale 1ns/1ps
`default_nettype none

module spatz_vfu (
	input  logic             clk_i,
	input  logic             reset_i,
	input  spatz_pkg::op_e   op_i,
	input  spatz_pkg::elen_t a_i,
	input  spatz_pkg::elen_t b_i,
	input  spatz_pkg::elen_t scalar_i,
	input  logic             use_scalar_i,
	input  logic             acc_init_i,
	input  logic             acc_en_i,
	output spatz_pkg::elen_t result_o,
	output spatz_pkg::elen_t acc_o
);
	import spatz_pkg::*;

	elen_t op_a;
	elen_t acc_q;

	// a is vs1 or the scalar, b is vs2
	assign op_a = use_scalar_i ? scalar_i : a_i;

	always_comb begin
		unique case (op_i)
			VADD:    result_o = b_i + op_a;
			VSUB:    result_o = b_i - op_a;
			VAND:    result_o = b_i & op_a;
			VOR:     result_o = b_i | op_a;
			VXOR:    result_o = b_i ^ op_a;
			VMV_VX:  result_o = op_a;
			VREDSUM: result_o = acc_q;
			default: result_o = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			acc_q <= '0;
		end else if (acc_init_i || acc_en_i) begin
			acc_q <= (acc_init_i ? op_a : acc_q) + (acc_en_i ? b_i : '0);
		end
	end

	assign acc_o = acc_q;

endmodule

`default_nettype wire

/* source/spatz.sv */
// Top level of the vector unit. Takes strobed instructions with their
// scalar operands and returns scalar results, illegal flags and a busy level.
`timescale 1ns/1ps
`default_nettype none

module spatz (
	input  logic             clk_i,
	input  logic             reset_i,
	input  logic [31:0]      instr_i,
	input  logic             instr_valid_i,
	input  spatz_pkg::elen_t rs1_i,
	input  spatz_pkg::elen_t rs2_i,
	output logic             instr_illegal_o,
	output spatz_pkg::elen_t rd_o,
	output logic             rd_valid_o,
	output logic             busy_o
);
	import spatz_pkg::*;

	//////////////////////////////
	// Signals
	//////////////////////////////

	spatz_req_t req;
	vlen_t      vl;
	vtype_t     vtype;
	logic       cfg_we;
	logic       cnt_start;
	logic       cnt_step;
	logic       last;
	vlen_t      elem_idx;
	logic       vrf_we;
	vreg_t      vrf_waddr;
	vlen_t      vrf_welem;
	vreg_t      vrf_raddr1;
	vreg_t      vrf_raddr2;
	vlen_t      vrf_relem;
	elen_t      vrf_rdata1;
	elen_t      vrf_rdata2;
	logic       acc_init;
	logic       acc_en;
	op_e        op;
	elen_t      scalar;
	logic       use_scalar;
	elen_t      result;
	elen_t      acc;

	//////////////////////////////
	// Instances
	//////////////////////////////

	spatz_decoder i_decoder (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.instr_i       (instr_i),
		.instr_valid_i (instr_valid_i),
		.rs1_i         (rs1_i),
		.rs2_i         (rs2_i),
		.req_o         (req)
	);

	// vstart stays zero, nothing reads it yet
	spatz_vcsr i_vcsr (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.cfg_we_i (cfg_we),
		.req_i    (req),
		.vl_o     (vl),
		.vstart_o (),
		.vtype_o  (vtype)
	);

	spatz_controller i_controller (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.req_i           (req),
		.vl_i            (vl),
		.vtype_i         (vtype),
		.last_i          (last),
		.elem_idx_i      (elem_idx),
		.vs2_data_i      (vrf_rdata2),
		.acc_i           (acc),
		.cfg_we_o        (cfg_we),
		.cnt_start_o     (cnt_start),
		.cnt_step_o      (cnt_step),
		.vrf_we_o        (vrf_we),
		.vrf_waddr_o     (vrf_waddr),
		.vrf_welem_o     (vrf_welem),
		.vrf_raddr1_o    (vrf_raddr1),
		.vrf_raddr2_o    (vrf_raddr2),
		.vrf_relem_o     (vrf_relem),
		.acc_init_o      (acc_init),
		.acc_en_o        (acc_en),
		.op_o            (op),
		.rs1_o           (scalar),
		.use_scalar_o    (use_scalar),
		.busy_o          (busy_o),
		.instr_illegal_o (instr_illegal_o),
		.rd_o            (rd_o),
		.rd_valid_o      (rd_valid_o)
	);

	spatz_elem_counter i_counter (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.start_i (cnt_start),
		.step_i  (cnt_step),
		.vl_i    (vl),
		.idx_o   (elem_idx),
		.last_o  (last)
	);

	spatz_vrf i_vrf (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.we_i     (vrf_we),
		.waddr_i  (vrf_waddr),
		.welem_i  (vrf_welem),
		.wdata_i  (result),
		.raddr1_i (vrf_raddr1),
		.raddr2_i (vrf_raddr2),
		.relem_i  (vrf_relem),
		.rdata1_o (vrf_rdata1),
		.rdata2_o (vrf_rdata2)
	);

	spatz_vfu i_vfu (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.op_i         (op),
		.a_i          (vrf_rdata1),
		.b_i          (vrf_rdata2),
		.scalar_i     (scalar),
		.use_scalar_i (use_scalar),
		.acc_init_i   (acc_init),
		.acc_en_i     (acc_en),
		.result_o     (result),
		.acc_o        (acc)
	);

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// Clock and reset for the testbench. 10 ns period, reset held 10 cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk_o,
	output logic reset_o
);
	localparam int RESET_CYCLES = 10;

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* tests/tb_spatz_assert.sv */
// Protocol assertions on the vector unit outputs, bound into spatz.
// Failure counts are read by the testbench top.
`timescale 1ns/1ps
`default_nettype none

module tb_spatz_assert (
	input logic        clk_i,
	input logic        reset_i,
	input logic [31:0] instr_i,
	input logic        instr_valid_i,
	input logic        busy_i,
	input logic        rd_valid_i,
	input logic        instr_illegal_i
);
	import spatz_pkg::*;

	logic is_cfg;
	int c_reset = 0;
	int c_pulse = 0;
	int c_cfg = 0;
	int c_busy = 0;
	int fail_cnt;

	assign fail_cnt = c_reset + c_pulse + c_cfg + c_busy;

	// vsetvli, or vsetvl with its funct7 bits clear
	assign is_cfg = (instr_i[6:0] == OPV) && (instr_i[14:12] == OPCFG)
		&& (!instr_i[31] || instr_i[30:25] == '0);

	// Outputs quiet while in reset and right after it
	assert property (@(posedge clk_i)
		$past(reset_i) |-> !(busy_i || rd_valid_i || instr_illegal_i))
	else begin
		$error("busy, rd_valid or instr_illegal high after reset");
		c_reset = c_reset + 1;
	end

	assert property (@(posedge clk_i) disable iff (reset_i)
		instr_illegal_i |=> !instr_illegal_i)
	else begin
		$error("instr_illegal_o longer than one cycle");
		c_pulse = c_pulse + 1;
	end

	assert property (@(posedge clk_i) disable iff (reset_i)
		rd_valid_i |=> !rd_valid_i)
	else begin
		$error("rd_valid_o longer than one cycle");
		c_pulse = c_pulse + 1;
	end

	// Configuration strobe taken while idle answers two cycles later
	assert property (@(posedge clk_i) disable iff (reset_i)
		$past(instr_valid_i && !busy_i && is_cfg, 2) |-> rd_valid_i)
	else begin
		$error("no rd_valid_o two cycles after a legal configuration");
		c_cfg = c_cfg + 1;
	end

	assert property (@(posedge clk_i) disable iff (reset_i)
		!(busy_i && rd_valid_i))
	else begin
		$error("busy_o and rd_valid_o high together");
		c_busy = c_busy + 1;
	end

endmodule

bind spatz tb_spatz_assert i_spatz_assert (
	.clk_i           (clk_i),
	.reset_i         (reset_i),
	.instr_i         (instr_i),
	.instr_valid_i   (instr_valid_i),
	.busy_i          (busy_o),
	.rd_valid_i      (rd_valid_o),
	.instr_illegal_i (instr_illegal_o)
);

`default_nettype wire

/* tests/tb_spatz.sv */
// Testbench top for the vector unit. Runs configuration, element-wise,
// reduction and illegal-instruction sequences against a small model.
`timescale 1ns/1ps
`default_nettype none

module tb_spatz;
	import spatz_pkg::*;

	localparam int N_INSTR = 60;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_CYCLES = N_INSTR * (MAXVL + 4) + 2 * RESET_CYCLES;
	localparam int WAIT_LIMIT = MAXVL + 8;
	// Low vtype byte: vsew in [5:3], vlmul in [2:0]
	localparam logic [7:0] VT_E32 = 8'h10;
	localparam logic [7:0] VT_E64 = 8'h18;
	localparam logic [7:0] VT_RES = 8'h14;

	logic        clk;
	logic        reset;
	logic [31:0] instr;
	logic        instr_valid;
	elen_t       rs1;
	elen_t       rs2;
	logic        instr_illegal;
	elen_t       rd;
	logic        rd_valid;
	logic        busy;

	// Model state
	elen_t       vreg_m [32][MAXVL];
	int unsigned vl_m;
	int          check_errors = 0;
	int          cycles = 0;

	tb_clock clock_i (.clk_o(clk), .reset_o(reset));

	spatz spatz_i (
		.clk_i           (clk),
		.reset_i         (reset),
		.instr_i         (instr),
		.instr_valid_i   (instr_valid),
		.rs1_i           (rs1),
		.rs2_i           (rs2),
		.instr_illegal_o (instr_illegal),
		.rd_o            (rd),
		.rd_valid_o      (rd_valid),
		.busy_o          (busy)
	);

	//////////////////////////////
	// Encoders and helpers
	//////////////////////////////

	function automatic logic [31:0] enc_arith(input logic [5:0] f6, input logic vm,
		input logic [4:0] vs2_r, input logic [4:0] src_r, input logic [2:0] f3,
		input logic [4:0] vd);
		return {f6, vm, vs2_r, src_r, f3, vd, 7'b1010111};
	endfunction

	function automatic logic [5:0] arith_f6(input int k);
		case (k)
			0: return 6'b000000;
			1: return 6'b000010;
			2: return 6'b001001;
			3: return 6'b001010;
			default: return 6'b001011;
		endcase
	endfunction

	task automatic check_value(input string name, input elen_t got, input elen_t exp);
		assert (got == exp) else begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic send(input logic [31:0] word, input elen_t a, input elen_t b);
		@(posedge clk);
		instr <= word;
		rs1 <= a;
		rs2 <= b;
		instr_valid <= 1'b1;
		@(posedge clk);
		instr_valid <= 1'b0;
	endtask

	task automatic expect_rd(input elen_t exp);
		int n;
		n = 0;
		@(negedge clk);
		check_value("instr_illegal_o", elen_t'(instr_illegal), '0);
		while (!rd_valid && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!rd_valid) begin
			$display("Error: rd_valid_o never arrived");
			check_errors++;
		end else begin
			check_value("rd_o", rd, exp);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			$display("Error: busy_o did not fall");
			check_errors++;
		end
	endtask

	task automatic run_illegal(input logic [31:0] word);
		send(word, 32'h5, '0);
		@(negedge clk);
		check_value("instr_illegal_o", elen_t'(instr_illegal), 32'd1);
	endtask

	// vsetvli or vsetvl, vl follows the RVV AVL rule for VLMAX = MAXVL
	task automatic configure(input logic use_reg, input logic [4:0] rd_r,
		input logic [4:0] rs1_r, input elen_t avl, input logic [7:0] vt);
		logic [31:0] word;
		if (use_reg)
			word = {7'b1000000, 5'd7, rs1_r, 3'b111, rd_r, 7'b1010111};
		else
			word = {1'b0, 3'b000, vt, rs1_r, 3'b111, rd_r, 7'b1010111};
		send(word, avl, {24'b0, vt});
		if (vt[5:3] > 3'd2 || vt[2:0] == 3'd4)
			vl_m = 0;
		else if (rs1_r != '0)
			vl_m = (avl > MAXVL) ? MAXVL : avl;
		else if (rd_r != '0)
			vl_m = MAXVL;
		expect_rd(elen_t'(vl_m));
	endtask

	task automatic start_vec(input logic [5:0] f6, input logic [2:0] f3,
		input logic [4:0] vd, input logic [4:0] vs2_r, input logic [4:0] src_r,
		input elen_t x);
		elen_t sum;
		elen_t a;
		elen_t b;
		send(enc_arith(f6, 1'b1, vs2_r, src_r, f3, vd), x, '0);
		if (f3 == 3'b010) begin
			// vredsum: vs1[0] plus vs2 over vl elements into vd[0]
			sum = vreg_m[src_r][0];
			for (int i = 0; i < vl_m; i++)
				sum += vreg_m[vs2_r][i];
			if (vl_m != 0)
				vreg_m[vd][0] = sum;
		end else begin
			for (int i = 0; i < vl_m; i++) begin
				a = (f3 == 3'b100) ? x : vreg_m[src_r][i];
				b = vreg_m[vs2_r][i];
				case (f6)
					6'b000010: vreg_m[vd][i] = b - a;
					6'b001001: vreg_m[vd][i] = b & a;
					6'b001010: vreg_m[vd][i] = b | a;
					6'b001011: vreg_m[vd][i] = b ^ a;
					6'b010111: vreg_m[vd][i] = a;
					default:   vreg_m[vd][i] = b + a;
				endcase
			end
		end
	endtask

	task automatic run_vec(input logic [5:0] f6, input logic [2:0] f3,
		input logic [4:0] vd, input logic [4:0] vs2_r, input logic [4:0] src_r,
		input elen_t x);
		start_vec(f6, f3, vd, vs2_r, src_r, x);
		@(negedge clk);
		check_value("instr_illegal_o", elen_t'(instr_illegal), '0);
		check_value("busy_o", elen_t'(busy), 32'd1);
		wait_idle();
	endtask

	// vmv.x.s into x10
	task automatic read_elem0(input logic [4:0] vs2_r);
		send(enc_arith(6'b010000, 1'b1, vs2_r, 5'd0, 3'b010, 5'd10), '0, '0);
		expect_rd(vreg_m[vs2_r][0]);
	endtask

	//////////////////////////////
	// Timeout
	//////////////////////////////

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Error: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		int assert_errors;
		instr <= '0;
		instr_valid <= 1'b0;
		rs1 <= '0;
		rs2 <= '0;
		void'($urandom(75581));
		vl_m = 0;
		for (int r = 0; r < 32; r++)
			for (int e = 0; e < MAXVL; e++)
				vreg_m[r][e] = '0;
		@(negedge clk);
		while (reset)
			@(negedge clk);

		// AVL clipping, VLMAX request and keep-vl
		for (int i = 0; i < 10; i++)
			configure(1'b0, 5'd5, 5'd6, $urandom_range(10, 0), VT_E32);
		configure(1'b0, 5'd5, 5'd0, 32'd1, VT_E32);
		configure(1'b0, 5'd5, 5'd6, 32'd3, VT_E32);
		configure(1'b0, 5'd0, 5'd0, 32'd9, VT_E32);

		// Unsupported vtype sets vill, vector ops then rejected
		configure(1'b1, 5'd5, 5'd6, 32'd4, VT_E64);
		run_illegal(enc_arith(6'b000000, 1'b1, 5'd2, 5'd1, 3'b000, 5'd3));
		configure(1'b1, 5'd5, 5'd6, 32'd4, VT_RES);
		run_illegal(enc_arith(6'b000000, 1'b1, 5'd2, 5'd6, 3'b100, 5'd3));
		configure(1'b0, 5'd5, 5'd6, 32'd4, VT_E32);

		// Broadcasts, then each element-wise op
		run_vec(6'b010111, 3'b100, 5'd1, 5'd0, 5'd6, $urandom());
		run_vec(6'b010111, 3'b100, 5'd2, 5'd0, 5'd6, $urandom());
		for (int k = 0; k < 5; k++) begin
			run_vec(arith_f6(k), 3'b000, 5'(3 + k), 5'd2, 5'd1, '0);
			read_elem0(5'(3 + k));
		end
		run_vec(6'b000000, 3'b100, 5'd8, 5'd2, 5'd6, $urandom());
		read_elem0(5'd8);
		configure(1'b0, 5'd5, 5'd6, 32'd0, VT_E32);
		run_vec(6'b000000, 3'b000, 5'd3, 5'd1, 5'd1, '0);
		read_elem0(5'd3);

		// Reductions over vl 1 to 4
		for (int v = 1; v <= 4; v++) begin
			configure(1'b0, 5'd5, 5'd6, elen_t'(v), VT_E32);
			run_vec(6'b000000, 3'b010, 5'd10, 5'd2, 5'd1, '0);
			read_elem0(5'd10);
		end

		// Bad encodings and a strobe during execution
		run_illegal(32'h00000013);
		read_elem0(5'd3);
		run_illegal(enc_arith(6'b010000, 1'b1, 5'd0, 5'd6, 3'b110, 5'd3));
		read_elem0(5'd3);
		run_illegal(enc_arith(6'b000010, 1'b0, 5'd2, 5'd1, 3'b000, 5'd3));
		read_elem0(5'd3);
		start_vec(6'b000000, 3'b000, 5'd9, 5'd2, 5'd1, '0);
		run_illegal(enc_arith(6'b001011, 1'b1, 5'd2, 5'd1, 3'b000, 5'd3));
		wait_idle();
		read_elem0(5'd3);
		read_elem0(5'd9);

		assert_errors = spatz_i.i_spatz_assert.fail_cnt;
		$display("Errors: %0d model checks, %0d assertions", check_errors, assert_errors);
		if (check_errors == 0 && assert_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
source/spatz_pkg.sv
source/spatz_decoder.sv
source/spatz_vcsr.sv
source/spatz_controller.sv
source/spatz_elem_counter.sv
source/spatz_vrf.sv
source/spatz_vfu.sv
source/spatz.sv
tests/tb_clock.sv
tests/tb_spatz_assert.sv
tests/tb_spatz.sv

/* Makefile */
# Verilator build and run for the vector unit testbench

VERILATOR ?= verilator
VFLAGS    = --binary --assert --timing -Wno-fatal -j 0
TOP       = tb_spatz
FLIST     = flist.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FLIST))
PASS_MSG  = Verification passed

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-$(SIM_BIN) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
